// File: all.f
+incdir+design
design/dither_pkg.sv
design/sample_avg.sv
design/dither_gen.sv
design/dither_regs.sv
design/dither_top.sv
verif/tb_dither_checker.sv
verif/tb_dither_top.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_dither_top -f all.f -o tb_dither_sim \
    && ./obj_dir/tb_dither_sim | tee /dev/stderr | grep "TB PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/tb_dither_top.sv
`timescale 1ns/1ps
`include "dither_cfg.svh"

module tb_dither_top
    import dither_pkg::*;
();

    localparam int TMO         = 2000;
    localparam int ROWS        = 6;
    localparam int RESP_OKAY   = 0;
    localparam int RESP_SLVERR = 2;

    logic                         i_clk = 1'b0;
    logic                         i_rst_n = 1'b0;
    logic [`DITHER_AXI_AW-1:0]    i_awaddr = '0;
    logic                         i_awvalid = 1'b0;
    logic                         o_awready;
    logic [31:0]                  i_wdata = '0;
    logic                         i_wvalid = 1'b0;
    logic                         o_wready;
    logic                         o_bvalid;
    logic [1:0]                   o_bresp;
    logic                         i_bready = 1'b1;
    logic [`DITHER_AXI_AW-1:0]    i_araddr = '0;
    logic                         i_arvalid = 1'b0;
    logic                         o_arready;
    logic                         o_rvalid;
    logic [31:0]                  o_rdata;
    logic [1:0]                   o_rresp;
    logic                         i_rready = 1'b0;
    logic                         i_adc_valid = 1'b0;
    logic signed [`DITHER_DW-1:0] i_adc_data = '0;
    logic signed [`DITHER_DW-1:0] o_mod_out;
    logic                         o_step_trig;
    logic                         o_irq;

    int                           row_idx = 0;
    logic [31:0]                  row_wait = '0;
    logic signed [`DITHER_DW-1:0] row_amp = '0;
    logic signed [`DITHER_DW-1:0] row_bias = '0;
    logic                         row_active = 1'b0;
    logic [2:0]                   gap_cnt = '0;
    int                           errors;
    int                           timeouts;
    int                           tbl_wait [ROWS];
    int                           tbl_avg  [ROWS];
    int                           tbl_amp  [ROWS];
    int                           tbl_bias [ROWS];
    int unsigned                  rand_state;

    dither_top dither_top_inst (.*);

    tb_dither_checker checker_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_mod_out   (o_mod_out),
        .i_step_trig (o_step_trig),
        .i_irq       (o_irq),
        .i_active    (row_active),
        .i_row       (row_idx),
        .i_bias      (row_bias),
        .i_amp       (row_amp),
        .i_wait      (row_wait),
        .o_errors    (errors),
        .o_timeouts  (timeouts)
    );

    always #20 i_clk = ~i_clk;

    // plant, one cycle behind the modulation, idle every fifth cycle
    always @(posedge i_clk) begin
        gap_cnt     <= (gap_cnt == 3'd4) ? 3'd0 : gap_cnt + 3'd1;
        i_adc_valid <= (gap_cnt != 3'd4);
        i_adc_data  <= 16'(3 * int'(o_mod_out) + 100);
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input int exp_resp);
        int n;
        n = 0;
        @(posedge i_clk);
        i_awaddr  <= addr;
        i_awvalid <= 1'b1;
        i_wdata   <= data;
        i_wvalid  <= 1'b1;
        @(posedge i_clk);
        while (!o_awready && n < TMO) begin
            @(posedge i_clk);
            n++;
        end
        i_awvalid <= 1'b0;
        i_wvalid  <= 1'b0;
        if (n >= TMO) begin
            checker_inst.note_timeout($sformatf("write accept at 0x%02h", addr));
        end
        n = 0;
        @(posedge i_clk);
        while (!o_bvalid && n < TMO) begin
            @(posedge i_clk);
            n++;
        end
        if (n >= TMO) begin
            checker_inst.note_timeout($sformatf("write response at 0x%02h", addr));
        end
        checker_inst.compare_value($sformatf("write 0x%02h bresp", addr), exp_resp,
                                   int'(o_bresp));
    endtask

    task automatic read_reg(input logic [7:0] addr, input int hold, input int exp_resp,
                            output logic [31:0] data);
        int n;
        n = 0;
        @(posedge i_clk);
        i_araddr  <= addr;
        i_arvalid <= 1'b1;
        i_rready  <= (hold == 0);
        @(posedge i_clk);
        while (!o_arready && n < TMO) begin
            @(posedge i_clk);
            n++;
        end
        i_arvalid <= 1'b0;
        if (n >= TMO) begin
            checker_inst.note_timeout($sformatf("read accept at 0x%02h", addr));
        end
        n = 0;
        @(posedge i_clk);
        while (!o_rvalid && n < TMO) begin
            @(posedge i_clk);
            n++;
        end
        if (n >= TMO) begin
            checker_inst.note_timeout($sformatf("read data at 0x%02h", addr));
        end
        data = o_rdata;
        checker_inst.compare_value($sformatf("read 0x%02h rresp", addr), exp_resp,
                                   int'(o_rresp));
        // rready held low, the beat must not move
        for (n = 0; n < hold; n++) begin
            @(posedge i_clk);
            checker_inst.compare_value("rvalid under back-pressure", 1, int'(o_rvalid));
            checker_inst.compare_value("rdata under back-pressure", int'(data), int'(o_rdata));
        end
        if (hold > 0) begin
            i_rready <= 1'b1;
            @(posedge i_clk);
        end
        i_rready <= 1'b0;
    endtask

    task automatic wait_for_irq();
        int            n;
        dither_state_e st;
        n = 0;
        @(posedge i_clk);
        while (!o_irq && n < TMO) begin
            @(posedge i_clk);
            n++;
        end
        if (n >= TMO) begin
            st = dither_top_inst.dither_gen_inst.state;
            checker_inst.note_timeout($sformatf("o_irq (generator in %s)", st.name()));
        end
    endtask

    // two cycles at bias means the generator is back in RST
    task automatic wait_for_rest();
        int n;
        int same;
        n    = 0;
        same = 0;
        while (same < 2 && n < TMO) begin
            @(posedge i_clk);
            n++;
            same = (o_mod_out == row_bias) ? same + 1 : 0;
        end
        if (same < 2) begin
            checker_inst.note_timeout("return of o_mod_out to bias");
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] rd_h;
        logic [31:0] rd_l;
        logic [31:0] rd_e;
        logic [31:0] rd_s;
        int          a;
        int          r;
        tbl_wait   = '{0, 3, 10, 25, 30, 40};
        tbl_avg    = '{7, 5, 4, 7, 3, 1};
        tbl_amp    = '{500, 250, 1000, 77, 0, 0};
        tbl_bias   = '{1000, -1200, 0, -300, 0, 0};
        rand_state = 59;
        for (r = 4; r < ROWS; r++) begin
            rand_state  = lcg_next(rand_state);
            tbl_amp[r]  = int'(rand_state >> 16) % 2000 + 1;
            rand_state  = lcg_next(rand_state);
            tbl_bias[r] = int'(rand_state >> 16) % 4000 - 2000;
        end

        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);
        checker_inst.compare_value("reset o_mod_out", 0, int'(o_mod_out));
        checker_inst.compare_value("reset o_step_trig", 0, int'(o_step_trig));
        checker_inst.compare_value("reset o_irq", 0, int'(o_irq));
        for (a = 0; a <= 32; a += 4) begin
            read_reg(8'(a), 0, RESP_OKAY, rd);
            checker_inst.compare_value($sformatf("reset read 0x%02h", a), 0, int'(rd));
        end

        for (r = 0; r < ROWS; r++) begin
            @(posedge i_clk);
            row_idx  <= r;
            row_wait <= tbl_wait[r];
            row_amp  <= 16'(tbl_amp[r]);
            row_bias <= 16'(tbl_bias[r]);
            write_reg(`DITHER_REG_WAIT, tbl_wait[r], RESP_OKAY);
            write_reg(`DITHER_REG_AVG, tbl_avg[r], RESP_OKAY);
            write_reg(`DITHER_REG_AMP, tbl_amp[r], RESP_OKAY);
            write_reg(`DITHER_REG_BIAS, tbl_bias[r], RESP_OKAY);
            row_active <= 1'b1;
            write_reg(`DITHER_REG_CTRL, 32'd1, RESP_OKAY);
            wait_for_irq();
            read_reg(`DITHER_REG_DATA_H, 0, RESP_OKAY, rd_h);
            read_reg(`DITHER_REG_DATA_L, 0, RESP_OKAY, rd_l);
            read_reg(`DITHER_REG_ERROR, 0, RESP_OKAY, rd_e);
            read_reg(`DITHER_REG_STATUS, 0, RESP_OKAY, rd_s);
            checker_inst.expect_results($signed(rd_h), $signed(rd_l), $signed(rd_e));
            checker_inst.expect_status(rd_s);
            write_reg(`DITHER_REG_CTRL, 32'd0, RESP_OKAY);
            wait_for_rest();
            row_active <= 1'b0;
        end

        // read-only and unmapped offsets
        read_reg(`DITHER_REG_DATA_H, 0, RESP_OKAY, rd_h);
        write_reg(`DITHER_REG_DATA_H, 32'h0000_1234, RESP_SLVERR);
        read_reg(`DITHER_REG_DATA_H, 0, RESP_OKAY, rd);
        checker_inst.compare_value("DATA_H after read-only write", int'(rd_h), int'(rd));
        read_reg(8'h40, 0, RESP_SLVERR, rd);
        checker_inst.compare_value("unmapped read data", 0, int'(rd));
        read_reg(`DITHER_REG_AMP, 4, RESP_OKAY, rd);
        checker_inst.compare_value("AMP under back-pressure", tbl_amp[ROWS-1], $signed(rd));

        @(posedge i_clk);
        $display("closing: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verif/tb_dither_checker.sv
`timescale 1ns/1ps
`include "dither_cfg.svh"

module tb_dither_checker (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic signed [`DITHER_DW-1:0] i_mod_out,
    input  logic                         i_step_trig,
    input  logic                         i_irq,
    input  logic                         i_active,
    input  int                           i_row,
    input  logic signed [`DITHER_DW-1:0] i_bias,
    input  logic signed [`DITHER_DW-1:0] i_amp,
    input  logic [31:0]                  i_wait,
    output int                           o_errors,
    output int                           o_timeouts
);

    int                           err_cnt = 0;
    int                           mon_err_cnt = 0;
    int                           tmo_cnt = 0;
    int                           irq_cnt = 0;
    int                           run_len = 0;
    int                           hi;
    int                           lo;
    logic                         armed = 1'b0;
    logic                         stepped = 1'b0;
    logic signed [`DITHER_DW-1:0] prev_mod = '0;

    assign o_errors   = err_cnt + mon_err_cnt;
    assign o_timeouts = tmo_cnt;

    // modulation levels and settling, sampled once per cycle
    always @(posedge i_clk) begin
        hi = int'(i_bias) + int'(i_amp);
        lo = int'(i_bias) - int'(i_amp);
        if (i_irq && i_rst_n) begin
            irq_cnt++;
        end
        if (!i_active) begin
            armed   = 1'b0;
            stepped = 1'b0;
        end else if (i_step_trig) begin
            armed = 1'b1;
        end
        if (armed) begin
            if (int'(i_mod_out) != hi && int'(i_mod_out) != lo && i_mod_out != i_bias) begin
                $display("** Error row%0d mod_out level: expected %0d, %0d or %0d, actual %0d",
                         i_row, hi, lo, i_bias, i_mod_out);
                mon_err_cnt++;
            end
            if (i_mod_out != prev_mod && i_mod_out != i_bias && !i_step_trig) begin
                $display("** Error row%0d step_trig at level change: expected 1, actual 0",
                         i_row);
                mon_err_cnt++;
            end
            if (i_mod_out != prev_mod && stepped && run_len < int'(i_wait) + 1) begin
                $display("** Error row%0d settle hold: expected at least %0d, actual %0d",
                         i_row, int'(i_wait) + 1, run_len);
                mon_err_cnt++;
            end
        end
        if (i_step_trig) begin
            run_len = 1;
            stepped = armed;
        end else if (i_mod_out == prev_mod) begin
            run_len++;
        end else begin
            stepped = 1'b0;
        end
        prev_mod = i_mod_out;
    end

    task automatic compare_value(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    // every sample in a level is equal, so the mean is exact at any depth
    task automatic expect_results(input int dh, input int dl, input int er);
        int hi_mean;
        int lo_mean;
        hi_mean = 3 * (int'(i_bias) + int'(i_amp)) + 100;
        lo_mean = 3 * (int'(i_bias) - int'(i_amp)) + 100;
        compare_value($sformatf("row%0d DATA_H", i_row), hi_mean, dh);
        compare_value($sformatf("row%0d DATA_L", i_row), lo_mean, dl);
        compare_value($sformatf("row%0d ERROR", i_row), 6 * int'(i_amp), er);
    endtask

    task automatic expect_status(input logic [31:0] st);
        compare_value($sformatf("row%0d STATUS new flag", i_row), 0, int'(st[0]));
        compare_value($sformatf("row%0d STATUS count", i_row), irq_cnt % 65536,
                      int'(st[31:16]));
    endtask

    task automatic note_timeout(input string what);
        $display("timeout: %s did not happen in time", what);
        tmo_cnt++;
    endtask

endmodule

// File: design/dither_top.sv
`timescale 1ns/1ps
`include "dither_cfg.svh"

module dither_top
    import dither_pkg::*;
(
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic [`DITHER_AXI_AW-1:0]    i_awaddr,
    input  logic                         i_awvalid,
    output logic                         o_awready,
    input  logic [31:0]                  i_wdata,
    input  logic                         i_wvalid,
    output logic                         o_wready,
    output logic                         o_bvalid,
    output logic [1:0]                   o_bresp,
    input  logic                         i_bready,
    input  logic [`DITHER_AXI_AW-1:0]    i_araddr,
    input  logic                         i_arvalid,
    output logic                         o_arready,
    output logic                         o_rvalid,
    output logic [31:0]                  o_rdata,
    output logic [1:0]                   o_rresp,
    input  logic                         i_rready,
    input  logic                         i_adc_valid,
    input  logic signed [`DITHER_DW-1:0] i_adc_data,
    output logic signed [`DITHER_DW-1:0] o_mod_out,
    output logic                         o_step_trig,
    output logic                         o_irq
);

    dither_cfg_t                  cfg;
    dither_result_t               result;
    logic                         result_stb;
    logic                         acq_start;
    logic [2:0]                   shift;
    logic                         avg_done;
    logic signed [`DITHER_DW-1:0] avg_mean;

    // interrupt is the result strobe itself
    assign o_irq = result_stb;

    dither_regs dither_regs_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_awaddr     (i_awaddr),
        .i_awvalid    (i_awvalid),
        .o_awready    (o_awready),
        .i_wdata      (i_wdata),
        .i_wvalid     (i_wvalid),
        .o_wready     (o_wready),
        .o_bvalid     (o_bvalid),
        .o_bresp      (o_bresp),
        .i_bready     (i_bready),
        .i_araddr     (i_araddr),
        .i_arvalid    (i_arvalid),
        .o_arready    (o_arready),
        .o_rvalid     (o_rvalid),
        .o_rdata      (o_rdata),
        .o_rresp      (o_rresp),
        .i_rready     (i_rready),
        .o_cfg        (cfg),
        .i_result     (result),
        .i_result_stb (result_stb)
    );

    dither_gen dither_gen_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cfg        (cfg),
        .o_acq_start  (acq_start),
        .o_shift      (shift),
        .i_avg_done   (avg_done),
        .i_avg_mean   (avg_mean),
        .o_mod_out    (o_mod_out),
        .o_step_trig  (o_step_trig),
        .o_result     (result),
        .o_result_stb (result_stb)
    );

    sample_avg sample_avg_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (acq_start),
        .i_shift (shift),
        .i_valid (i_adc_valid),
        .i_data  (i_adc_data),
        .o_done  (avg_done),
        .o_mean  (avg_mean)
    );

endmodule

// File: design/dither_regs.sv
`timescale 1ns/1ps
`include "dither_cfg.svh"

module dither_regs
    import dither_pkg::*;
(
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic [`DITHER_AXI_AW-1:0] i_awaddr,
    input  logic                      i_awvalid,
    output logic                      o_awready,
    input  logic [31:0]               i_wdata,
    input  logic                      i_wvalid,
    output logic                      o_wready,
    output logic                      o_bvalid,
    output logic [1:0]                o_bresp,
    input  logic                      i_bready,
    input  logic [`DITHER_AXI_AW-1:0] i_araddr,
    input  logic                      i_arvalid,
    output logic                      o_arready,
    output logic                      o_rvalid,
    output logic [31:0]               o_rdata,
    output logic [1:0]                o_rresp,
    input  logic                      i_rready,
    output dither_cfg_t               o_cfg,
    input  dither_result_t            i_result,
    input  logic                      i_result_stb
);

    logic           wr_fire;
    logic           wr_err;
    logic           rd_fire;
    logic           rd_err;
    logic [31:0]    rd_word;
    dither_result_t result_q;
    logic           new_flag;
    logic [15:0]    done_cnt;

    function automatic logic [31:0] sext(input logic [`DITHER_DW-1:0] v);
        sext = {{(32-`DITHER_DW){v[`DITHER_DW-1]}}, v};
    endfunction

    // address and data are taken together
    assign wr_fire   = i_awvalid & i_wvalid & ~o_bvalid;
    assign o_awready = wr_fire;
    assign o_wready  = wr_fire;

    assign rd_fire   = i_arvalid & ~o_rvalid;
    assign o_arready = ~o_rvalid;

    always_comb begin
        case (i_awaddr)
            `DITHER_REG_CTRL,
            `DITHER_REG_WAIT,
            `DITHER_REG_AVG,
            `DITHER_REG_AMP,
            `DITHER_REG_BIAS: wr_err = 1'b0;
            default:          wr_err = 1'b1;
        endcase
    end

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (i_araddr)
            `DITHER_REG_CTRL:   rd_word = {31'd0, o_cfg.enable};
            `DITHER_REG_WAIT:   rd_word = o_cfg.wait_cnt;
            `DITHER_REG_AVG:    rd_word = {29'd0, o_cfg.avg_sel};
            `DITHER_REG_AMP:    rd_word = sext(o_cfg.amp);
            `DITHER_REG_BIAS:   rd_word = sext(o_cfg.bias);
            `DITHER_REG_DATA_H: rd_word = sext(result_q.data_h);
            `DITHER_REG_DATA_L: rd_word = sext(result_q.data_l);
            `DITHER_REG_ERROR:  rd_word = sext(result_q.error);
            `DITHER_REG_STATUS: rd_word = {done_cnt, 15'd0, new_flag};
            default:            rd_err  = 1'b1;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cfg <= '0;
        end else if (wr_fire && !wr_err) begin
            case (i_awaddr)
                `DITHER_REG_CTRL: o_cfg.enable   <= i_wdata[0];
                `DITHER_REG_WAIT: o_cfg.wait_cnt <= i_wdata;
                `DITHER_REG_AVG:  o_cfg.avg_sel  <= i_wdata[2:0];
                `DITHER_REG_AMP:  o_cfg.amp      <= i_wdata[`DITHER_DW-1:0];
                `DITHER_REG_BIAS: o_cfg.bias     <= i_wdata[`DITHER_DW-1:0];
                default:          o_cfg          <= o_cfg;
            endcase
        end
    end

    // write response channel
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bvalid <= 1'b0;
            o_bresp  <= `DITHER_RESP_OKAY;
        end else if (wr_fire) begin
            o_bvalid <= 1'b1;
            o_bresp  <= wr_err ? `DITHER_RESP_SLVERR : `DITHER_RESP_OKAY;
        end else if (i_bready) begin
            o_bvalid <= 1'b0;
        end
    end

    // read data holds while rready is low
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rvalid <= 1'b0;
            o_rdata  <= '0;
            o_rresp  <= `DITHER_RESP_OKAY;
        end else if (rd_fire) begin
            o_rvalid <= 1'b1;
            o_rdata  <= rd_word;
            o_rresp  <= rd_err ? `DITHER_RESP_SLVERR : `DITHER_RESP_OKAY;
        end else if (i_rready) begin
            o_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            result_q <= '0;
            new_flag <= 1'b0;
            done_cnt <= '0;
        end else begin
            if (i_result_stb) begin
                result_q <= i_result;
                done_cnt <= done_cnt + 16'd1;
            end
            // a fresh result wins over a clearing read in the same cycle
            if (i_result_stb) begin
                new_flag <= 1'b1;
            end else if (rd_fire && i_araddr == `DITHER_REG_ERROR) begin
                new_flag <= 1'b0;
            end
        end
    end

endmodule

// File: design/dither_gen.sv
`timescale 1ns/1ps
`include "dither_cfg.svh"

module dither_gen
    import dither_pkg::*;
(
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  dither_cfg_t                  i_cfg,
    output logic                         o_acq_start,
    output logic [2:0]                   o_shift,
    input  logic                         i_avg_done,
    input  logic signed [`DITHER_DW-1:0] i_avg_mean,
    output logic signed [`DITHER_DW-1:0] o_mod_out,
    output logic                         o_step_trig,
    output dither_result_t               o_result,
    output logic                         o_result_stb
);

    dither_state_e                state;
    dither_state_e                state_nx;
    dither_cfg_t                  cfg_q;
    logic [31:0]                  wait_q;
    logic                         entering_acq;
    logic signed [`DITHER_DW-1:0] data_h_q;
    logic signed [`DITHER_DW-1:0] data_l_q;
    logic signed [`DITHER_DW-1:0] error_q;
    logic signed [`DITHER_DW:0]   diff;

    // depth clamp, the averager never sees more than 64 samples
    assign o_shift = (cfg_q.avg_sel > `DITHER_MAX_SHIFT) ? `DITHER_MAX_SHIFT : cfg_q.avg_sel;

    assign o_result = '{data_h: data_h_q, data_l: data_l_q, error: error_q};

    assign entering_acq = (state_nx == ACQ_H && state != ACQ_H) ||
                          (state_nx == ACQ_L && state != ACQ_L);

    // one extra bit so the difference never wraps
    assign diff = {data_h_q[`DITHER_DW-1], data_h_q} - {i_avg_mean[`DITHER_DW-1], i_avg_mean};

    always_comb begin
        state_nx = state;
        case (state)
            RST: begin
                if (i_cfg.enable) begin
                    state_nx = DITHER_H;
                end
            end
            DITHER_H: begin
                state_nx = (cfg_q.wait_cnt == '0) ? ACQ_H : WAIT_STABLE_H;
            end
            WAIT_STABLE_H: begin
                if (wait_q == '0) begin
                    state_nx = ACQ_H;
                end
            end
            ACQ_H: begin
                if (i_avg_done) begin
                    state_nx = DITHER_L;
                end
            end
            DITHER_L: begin
                state_nx = (cfg_q.wait_cnt == '0) ? ACQ_L : WAIT_STABLE_L;
            end
            WAIT_STABLE_L: begin
                if (wait_q == '0) begin
                    state_nx = ACQ_L;
                end
            end
            ACQ_L: begin
                if (i_avg_done) begin
                    state_nx = OUT_GEN;
                end
            end
            OUT_GEN: begin
                // a cleared enable takes effect only here
                state_nx = i_cfg.enable ? DITHER_H : RST;
            end
            default: state_nx = RST;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= RST;
            wait_q       <= '0;
            o_mod_out    <= '0;
            o_step_trig  <= 1'b0;
            o_acq_start  <= 1'b0;
            o_result_stb <= 1'b0;
        end else begin
            state        <= state_nx;
            o_step_trig  <= (state_nx == DITHER_H) || (state_nx == DITHER_L);
            o_acq_start  <= entering_acq;
            o_result_stb <= (state_nx == OUT_GEN);

            // settle counter loads in the one-cycle dither states
            if (state == DITHER_H || state == DITHER_L) begin
                wait_q <= cfg_q.wait_cnt - 32'd1;
            end else if (state == WAIT_STABLE_H || state == WAIT_STABLE_L) begin
                wait_q <= wait_q - 32'd1;
            end

            // outputs line up with the state they belong to
            case (state_nx)
                DITHER_H: o_mod_out <= i_cfg.bias + i_cfg.amp;
                DITHER_L: o_mod_out <= cfg_q.bias - cfg_q.amp;
                OUT_GEN:  o_mod_out <= cfg_q.bias;
                default:  o_mod_out <= o_mod_out;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_nx == DITHER_H) begin
            cfg_q <= i_cfg;
        end
        if (state == ACQ_H && i_avg_done) begin
            data_h_q <= i_avg_mean;
        end
        if (state == ACQ_L && i_avg_done) begin
            data_l_q <= i_avg_mean;
            if (diff[`DITHER_DW] != diff[`DITHER_DW-1]) begin
                error_q <= diff[`DITHER_DW] ? {1'b1, {(`DITHER_DW-1){1'b0}}}
                                            : {1'b0, {(`DITHER_DW-1){1'b1}}};
            end else begin
                error_q <= diff[`DITHER_DW-1:0];
            end
        end
    end

endmodule

// File: design/sample_avg.sv
`timescale 1ns/1ps
`include "dither_cfg.svh"

module sample_avg (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_start,
    input  logic [2:0]                   i_shift,
    input  logic                         i_valid,
    input  logic signed [`DITHER_DW-1:0] i_data,
    output logic                         o_done,
    output logic signed [`DITHER_DW-1:0] o_mean
);

    logic                           busy;
    logic [6:0]                     cnt;
    logic [6:0]                     target;
    logic [2:0]                     shift_q;
    logic signed [`DITHER_SUMW-1:0] sum;
    logic signed [`DITHER_SUMW-1:0] data_ext;
    logic signed [`DITHER_SUMW-1:0] sum_shifted;

    assign target      = 7'd1 << shift_q;
    assign data_ext    = {{(`DITHER_SUMW-`DITHER_DW){i_data[`DITHER_DW-1]}}, i_data};
    // arithmetic shift keeps negative means correct
    assign sum_shifted = sum >>> shift_q;
    assign o_mean      = sum_shifted[`DITHER_DW-1:0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy   <= 1'b0;
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy && i_valid) begin
                cnt <= cnt + 7'd1;
                if (cnt + 7'd1 == target) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            sum     <= '0;
            shift_q <= i_shift;
        end else if (busy && i_valid) begin
            sum <= sum + data_ext;
        end
    end

endmodule

// File: design/dither_pkg.sv
`include "dither_cfg.svh"

package dither_pkg;

    // programmed by software, sampled by the generator at DITHER_H
    typedef struct packed {
        logic                         enable;
        logic [31:0]                  wait_cnt;
        logic [2:0]                   avg_sel;
        logic signed [`DITHER_DW-1:0] amp;
        logic signed [`DITHER_DW-1:0] bias;
    } dither_cfg_t;

    // one completed dither cycle
    typedef struct packed {
        logic signed [`DITHER_DW-1:0] data_h;
        logic signed [`DITHER_DW-1:0] data_l;
        logic signed [`DITHER_DW-1:0] error;
    } dither_result_t;

    typedef enum logic [2:0] {
        RST,
        DITHER_H,
        WAIT_STABLE_H,
        ACQ_H,
        DITHER_L,
        WAIT_STABLE_L,
        ACQ_L,
        OUT_GEN
    } dither_state_e;

endpackage

// File: design/dither_cfg.svh
`ifndef DITHER_CFG_SVH
`define DITHER_CFG_SVH

// sample and modulation width, two's complement
`define DITHER_DW           16
// wide enough for 64 full-scale samples
`define DITHER_SUMW         24
// deepest average is 2^6 samples
`define DITHER_MAX_SHIFT    3'd6

`define DITHER_AXI_AW       8

// register map
`define DITHER_REG_CTRL     8'h00
`define DITHER_REG_WAIT     8'h04
`define DITHER_REG_AVG      8'h08
`define DITHER_REG_AMP      8'h0C
`define DITHER_REG_BIAS     8'h10
`define DITHER_REG_DATA_H   8'h14
`define DITHER_REG_DATA_L   8'h18
`define DITHER_REG_ERROR    8'h1C
`define DITHER_REG_STATUS   8'h20

`define DITHER_RESP_OKAY    2'b00
`define DITHER_RESP_SLVERR  2'b10

`endif
